//--- char_row_gen.f
+incdir+include
source/char_row_pkg.sv
source/char_code_decoder.sv
source/cell_row_counter.sv
source/glyph_rom.sv
source/char_row_gen.sv
testbench/tb_clock_gen.sv
testbench/tb_char_row_gen.sv

//--- run.sh
#!/bin/sh
# Build and run the character row generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f char_row_gen.f \
  --top-module tb_char_row_gen \
  -o sim_char_row_gen

./obj_dir/sim_char_row_gen > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- testbench/tb_char_row_gen.sv
`timescale 1ns/100ps
`include "char_row_macros.svh"

module tb_char_row_gen;

  import char_row_pkg::*;

  localparam int NUM_LINES      = 1000;
  localparam int TIMEOUT_CYCLES = NUM_LINES + NUM_LINES / 5;  // Reset plus margin

  logic       end_of_line;
  logic       rst_n;
  logic       end_of_frame;
  logic [7:0] ascii;
  pixel_row_t pixel_row;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  int     model_line;

  tb_clock_gen u_clock (
    .end_of_line (end_of_line),
    .rst_n       (rst_n)
  );

  char_row_gen dut (
    .end_of_line  (end_of_line),
    .rst_n        (rst_n),
    .end_of_frame (end_of_frame),
    .ascii        (ascii),
    .pixel_row    (pixel_row)
  );

  // Six full-size reference rows per glyph from the top down
  function automatic logic [`GLYPH_LINES*`PIXEL_W-1:0] reference_glyph(input logic [7:0] code);
    case (code)
      8'h41:   return 96'h3FC0_C030_C030_FFF0_C030_C030;  // A
      8'h42:   return 96'hFFC0_C030_FFC0_C030_C030_FFC0;  // B
      8'h43:   return 96'h3FC0_C030_C000_C000_C030_3FC0;
      8'h44:   return 96'hFF00_C0C0_C030_C030_C0C0_FF00;
      8'h45:   return 96'hFFF0_C000_FFC0_C000_C000_FFF0;  // E
      8'h46:   return 96'hFFF0_C000_FFC0_C000_C000_C000;
      8'h47:   return 96'h3FC0_C030_C000_C3F0_C030_3FC0;
      8'h48:   return 96'hC030_C030_FFF0_C030_C030_C030;
      8'h49:   return 96'h3FF0_0300_0300_0300_0300_3FF0;  // I
      8'h4A:   return 96'h0030_0030_0030_C030_C030_3FC0;
      8'h4B:   return 96'hC0C0_C300_FC00_C300_C0C0_C030;
      8'h4C:   return 96'hC000_C000_C000_C000_C000_FFF0;
      8'h4D:   return 96'hC030_F0F0_CF30_C030_C030_C030;  // M
      8'h4E:   return 96'hC030_F030_CC30_C330_C0F0_C030;
      8'h4F:   return 96'h3FC0_C030_C030_C030_C030_3FC0;
      8'h50:   return 96'hFFC0_C030_C030_FFC0_C000_C000;
      8'h51:   return 96'h3FC0_C030_C030_CC30_C330_3FC0;  // Q
      8'h52:   return 96'hFFC0_C030_C030_FFC0_C0C0_C030;
      8'h53:   return 96'h3FC0_C000_3FC0_0030_C030_3FC0;
      8'h54:   return 96'hFFFC_0300_0300_0300_0300_0300;
      8'h55:   return 96'hC030_C030_C030_C030_C030_3FC0;  // U
      8'h56:   return 96'hC030_C030_C030_C030_30C0_0F00;
      8'h57:   return 96'hC030_C030_C030_C030_CF30_30C0;
      8'h58:   return 96'hC030_30C0_0F00_0F00_30C0_C030;
      8'h59:   return 96'hC00C_3030_0CC0_0300_0300_0300;  // Y
      8'h5A:   return 96'hFFF0_00C0_0300_0C00_3000_FFF0;
      8'h30:   return 96'h3FC0_C0F0_C330_CC30_F030_3FC0;  // Digit 0
      8'h31:   return 96'h3C00_CC00_0C00_0C00_0C00_FFC0;
      8'h32:   return 96'h3FC0_C030_0030_3FC0_C000_FFF0;
      8'h33:   return 96'h3FC0_C030_03C0_0030_C030_3FC0;
      8'h34:   return 96'h0300_0F00_3300_C300_FFF0_0300;
      8'h35:   return 96'hFFF0_C000_FFC0_0030_C030_3FC0;  // Digit 5
      8'h36:   return 96'h3FC0_C000_FFC0_C030_C030_3FC0;
      8'h37:   return 96'hFFF0_0030_00C0_0300_0C00_0C00;
      8'h38:   return 96'h3FC0_C030_3FC0_C030_C030_3FC0;
      8'h39:   return 96'h3FC0_C030_C030_3FF0_0030_3FC0;
      default: return '0;                                  // Unknown code gives a blank row
    endcase
  endfunction

  function automatic pixel_row_t expected_row(input logic [7:0] code, input int line);
    logic [`GLYPH_LINES*`PIXEL_W-1:0] word;
    int                               font_line;
    word = reference_glyph(code);
    if (line < `GLYPH_TOP || line >= `GLYPH_TOP + `GLYPH_LINES * `SCALE) begin
      return '0;
    end
    font_line = (line - `GLYPH_TOP) / `SCALE;  // Two scan lines per font row
    return word[(`GLYPH_LINES - 1 - font_line) * `PIXEL_W +: `PIXEL_W];
  endfunction

  // Frame restart takes priority over the wrap
  task automatic advance_model();
    if (end_of_frame) begin
      model_line = 0;
    end else if (model_line == `CELL_ROWS - 1) begin
      model_line = 0;
    end else begin
      model_line = model_line + 1;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    int          pick;
    r = $random(seed);
    end_of_frame = ((r % 25) == 0);            // About one line in 25
    r = $random(seed);
    if (r[1:0] != 2'b00) begin
      pick = int'(r[31:8] % `GLYPH_COUNT);
      if (pick < 26) begin
        ascii = `LETTER_BASE + 8'(pick);
      end else begin
        ascii = `DIGIT_BASE + 8'(pick - 26);
      end
    end else begin
      ascii = r[15:8];                         // Any byte
    end
  endtask

  task automatic check_row();
    pixel_row_t expected;
    expected = expected_row(ascii, model_line);
    checks++;
    assert (pixel_row === expected) else begin
      errors++;
      $display("FAIL pixel_row line %0d ascii %h: expected %h actual %h",
               model_line, ascii, expected, pixel_row);
    end
  endtask

  always @(posedge end_of_line) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d line cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    seed         = 32'hfb2;
    end_of_frame = 1'b0;
    ascii        = 8'h00;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    model_line   = 0;

    wait (rst_n === 1'b1);                     // One ns after the last reset edge
    for (int n = 0; n < NUM_LINES; n++) begin
      if (n > 0) begin
        @(posedge end_of_line);
        advance_model();
        #1;
      end
      if (n < `GLYPH_TOP) begin
        end_of_frame = 1'b0;                   // Letter A on the blank lines after reset
        ascii        = `LETTER_BASE;
      end else if (n < `CELL_ROWS) begin
        end_of_frame = 1'b0;                   // Rest of the first cell held on code ff
        ascii        = 8'hff;
      end else begin
        drive_random();
      end
      #2;
      check_row();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic end_of_line,
  output logic rst_n
);

  initial begin
    end_of_line = 1'b0;
    forever #2 end_of_line = ~end_of_line;  // 4 ns line period
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge end_of_line);
    #1 rst_n = 1'b1;                         // Released just after the fourth edge
  end

endmodule

//--- source/char_row_gen.sv
`timescale 1ns/100ps

module char_row_gen (
  input  logic                     end_of_line,
  input  logic                     rst_n,
  input  logic                     end_of_frame,
  input  logic [7:0]               ascii,
  output char_row_pkg::pixel_row_t pixel_row
);

  import char_row_pkg::*;

  char_sel_t sel;                       // Decoded character
  cell_pos_t pos;                       // Line position in the cell

  // Code to font index
  char_code_decoder u_decoder (
    .ascii (ascii),
    .sel   (sel)
  );

  // Line count, advanced once per scan line
  cell_row_counter u_counter (
    .end_of_line  (end_of_line),
    .rst_n        (rst_n),
    .end_of_frame (end_of_frame),
    .pos          (pos)
  );

  // Font lookup and horizontal doubling
  glyph_rom u_rom (
    .sel       (sel),
    .pos       (pos),
    .pixel_row (pixel_row)
  );

endmodule

//--- source/glyph_rom.sv
`timescale 1ns/100ps
`include "char_row_macros.svh"

module glyph_rom (
  input  char_row_pkg::char_sel_t  sel,
  input  char_row_pkg::cell_pos_t  pos,
  output char_row_pkg::pixel_row_t pixel_row
);

  import char_row_pkg::*;

  logic [`GLYPH_LINES*`GLYPH_W-1:0] glyph_word;
  glyph_bits_t                      glyph_rows [`GLYPH_LINES];
  glyph_bits_t                      row_bits;

  // Six compact rows per glyph with the top row in the upper byte
  always_comb begin
    case (sel.glyph)
      6'd0:    glyph_word = 48'h78_84_84_FC_84_84;  // A
      6'd1:    glyph_word = 48'hF8_84_F8_84_84_F8;  // B
      6'd2:    glyph_word = 48'h78_84_80_80_84_78;  // C
      6'd3:    glyph_word = 48'hF0_88_84_84_88_F0;  // D
      6'd4:    glyph_word = 48'hFC_80_F8_80_80_FC;  // E
      6'd5:    glyph_word = 48'hFC_80_F8_80_80_80;  // F
      6'd6:    glyph_word = 48'h78_84_80_9C_84_78;  // G
      6'd7:    glyph_word = 48'h84_84_FC_84_84_84;  // H
      6'd8:    glyph_word = 48'h7C_10_10_10_10_7C;  // I
      6'd9:    glyph_word = 48'h04_04_04_84_84_78;  // J
      6'd10:   glyph_word = 48'h88_90_E0_90_88_84;  // K
      6'd11:   glyph_word = 48'h80_80_80_80_80_FC;  // L
      6'd12:   glyph_word = 48'h84_CC_B4_84_84_84;  // M
      6'd13:   glyph_word = 48'h84_C4_A4_94_8C_84;  // N
      6'd14:   glyph_word = 48'h78_84_84_84_84_78;  // O
      6'd15:   glyph_word = 48'hF8_84_84_F8_80_80;  // P
      6'd16:   glyph_word = 48'h78_84_84_A4_94_78;  // Q
      6'd17:   glyph_word = 48'hF8_84_84_F8_88_84;  // R
      6'd18:   glyph_word = 48'h78_80_78_04_84_78;  // S
      6'd19:   glyph_word = 48'hFE_10_10_10_10_10;  // T
      6'd20:   glyph_word = 48'h84_84_84_84_84_78;  // U
      6'd21:   glyph_word = 48'h84_84_84_84_48_30;  // V
      6'd22:   glyph_word = 48'h84_84_84_84_B4_48;  // W
      6'd23:   glyph_word = 48'h84_48_30_30_48_84;  // X
      6'd24:   glyph_word = 48'h82_44_28_10_10_10;  // Y
      6'd25:   glyph_word = 48'hFC_08_10_20_40_FC;  // Z
      6'd26:   glyph_word = 48'h78_8C_94_A4_C4_78;  // 0
      6'd27:   glyph_word = 48'h60_A0_20_20_20_F8;  // 1
      6'd28:   glyph_word = 48'h78_84_04_78_80_FC;  // 2
      6'd29:   glyph_word = 48'h78_84_18_04_84_78;  // 3
      6'd30:   glyph_word = 48'h10_30_50_90_FC_10;  // 4
      6'd31:   glyph_word = 48'hFC_80_F8_04_84_78;  // 5
      6'd32:   glyph_word = 48'h78_80_F8_84_84_78;  // 6
      6'd33:   glyph_word = 48'hFC_04_08_10_20_20;  // 7
      6'd34:   glyph_word = 48'h78_84_78_84_84_78;  // 8
      6'd35:   glyph_word = 48'h78_84_84_7C_04_78;  // 9
      default: glyph_word = '0;
    endcase
  end

  // Split the word into rows with row 0 at the top of the glyph
  always_comb begin
    for (int r = 0; r < `GLYPH_LINES; r++) begin
      glyph_rows[r] = glyph_word[(`GLYPH_LINES - 1 - r) * `GLYPH_W +: `GLYPH_W];
    end
  end

  always_comb begin
    row_bits = '0;
    if (sel.known && pos.visible) begin
      row_bits = glyph_rows[pos.glyph_line];
    end
  end

  // Each font pixel becomes two output pixels with the MSB leftmost
  always_comb begin
    for (int i = 0; i < `GLYPH_W; i++) begin
      pixel_row[`SCALE * i +: `SCALE] = {`SCALE{row_bits[i]}};
    end
  end

endmodule

//--- source/cell_row_counter.sv
`timescale 1ns/100ps
`include "char_row_macros.svh"

module cell_row_counter (
  input  logic                    end_of_line,
  input  logic                    rst_n,
  input  logic                    end_of_frame,
  output char_row_pkg::cell_pos_t pos
);

  import char_row_pkg::*;

  localparam row_idx_t LAST_ROW  = row_idx_t'(`CELL_ROWS - 1);
  localparam row_idx_t TOP_ROW   = row_idx_t'(`GLYPH_TOP);
  localparam row_idx_t END_ROW   = row_idx_t'(`GLYPH_TOP + `GLYPH_LINES * `SCALE);
  localparam row_idx_t SCALE_ROW = row_idx_t'(`SCALE);

  row_idx_t row;
  row_idx_t glyph_off;

  always_ff @(posedge end_of_line) begin
    if (!rst_n) begin
      row <= '0;
    end else if (end_of_frame) begin
      row <= '0;                        // New frame starts a new cell
    end else if (row == LAST_ROW) begin
      row <= '0;
    end else begin
      row <= row + 1'b1;
    end
  end

  // Offset into the glyph area, only meaningful while visible
  assign glyph_off = row - TOP_ROW;

  assign pos.visible    = (row >= TOP_ROW) && (row < END_ROW);
  assign pos.glyph_line = glyph_line_t'(glyph_off / SCALE_ROW);  // Each font row spans two lines

endmodule

//--- source/char_code_decoder.sv
`timescale 1ns/100ps
`include "char_row_macros.svh"

module char_code_decoder (
  input  logic [7:0]              ascii,
  output char_row_pkg::char_sel_t sel
);

  import char_row_pkg::*;

  logic [7:0] letter_off;
  logic [7:0] digit_off;
  logic       is_letter;
  logic       is_digit;

  // Codes below a base wrap to large offsets and fail the range test
  assign letter_off = ascii - `LETTER_BASE;
  assign digit_off  = ascii - `DIGIT_BASE;

  assign is_letter = letter_off < `LETTER_COUNT;
  assign is_digit  = digit_off < `DIGIT_COUNT;

  always_comb begin
    sel.known = 1'b0;
    sel.glyph = '0;
    if (is_letter) begin
      sel.known = 1'b1;
      sel.glyph = glyph_idx_t'(letter_off);
    end else if (is_digit) begin
      sel.known = 1'b1;
      sel.glyph = glyph_idx_t'(digit_off + `LETTER_COUNT);  // Digits follow Z
    end
  end

endmodule

//--- source/char_row_pkg.sv
`include "char_row_macros.svh"

package char_row_pkg;

  // Line number inside one character cell
  typedef logic [$clog2(`CELL_ROWS)-1:0] row_idx_t;

  // Font index, letters 0..25 then digits 26..35
  typedef logic [$clog2(`GLYPH_COUNT)-1:0] glyph_idx_t;

  // Distinct font row, 0..5
  typedef logic [$clog2(`GLYPH_LINES)-1:0] glyph_line_t;

  // Compact font row and doubled output row
  typedef logic [`GLYPH_W-1:0] glyph_bits_t;
  typedef logic [`PIXEL_W-1:0] pixel_row_t;

  // Decoded character
  typedef struct packed {
    logic       known;                  // Code is a letter or digit
    glyph_idx_t glyph;
  } char_sel_t;

  // Position of the current line inside the cell
  typedef struct packed {
    logic        visible;               // Lines 2 to 13
    glyph_line_t glyph_line;
  } cell_pos_t;

endpackage

//--- include/char_row_macros.svh
`ifndef CHAR_ROW_MACROS_SVH
`define CHAR_ROW_MACROS_SVH

// Cell geometry in scan lines
`define CELL_ROWS    20
`define GLYPH_TOP    2
`define GLYPH_LINES  6
`define SCALE        2

// Font and output row widths
`define GLYPH_W      8
`define PIXEL_W      16
`define GLYPH_COUNT  36

// Character code ranges, letters first in the font
`define LETTER_BASE  8'h41
`define LETTER_COUNT 8'd26
`define DIGIT_BASE   8'h30
`define DIGIT_COUNT  8'd10

`endif
